// File: common/redmule_pkg.sv
// Datapath types for a fixed 4x4 tile with 16-bit unsigned elements that wrap modulo 2^16

`default_nettype none

package redmule_pkg;

  // Array geometry
  // ARRAY_W is the number of rows of Z, X and Y
  // ARRAY_H is the number of columns of Z, W and Y
  localparam int unsigned ARRAY_W = 4;
  localparam int unsigned ARRAY_H = 4;

  // Element and job length widths
  localparam int unsigned ELEM_W = 16;
  localparam int unsigned K_W    = 8;

  // One unsigned element
  typedef logic [ELEM_W-1:0] elem_t;

  // One X column per beat, element i feeds array row i
  typedef elem_t [ARRAY_W-1:0] x_col_t;

  // One W, Y or Z row per beat, element j feeds array column j
  typedef elem_t [ARRAY_H-1:0] row_t;

  // Selects one array row
  typedef logic [$clog2(ARRAY_W)-1:0] row_idx_t;

endpackage : redmule_pkg

`default_nettype wire

// File: common/redmule_ctrl_pkg.sv
// Control encodings between scheduler and engine, only NOP, LOAD_BIAS and MAC are legal ops

`default_nettype none

package redmule_ctrl_pkg;

  import redmule_pkg::*;

  // Job phases
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    LOAD_Y  = 2'd1,
    COMPUTE = 2'd2,
    STORE   = 2'd3
  } sched_state_e;

  // Engine operations, encoding 3 is unused
  typedef enum logic [1:0] {
    NOP       = 2'd0,
    LOAD_BIAS = 2'd1,
    MAC       = 2'd2
  } eng_op_e;

  // Command word, row is used by LOAD_BIAS and by readout
  typedef struct packed {
    eng_op_e  op;
    row_idx_t row;
  } eng_cmd_t;

endpackage : redmule_ctrl_pkg

`default_nettype wire

// File: source/redmule_stream_fifo.sv
// First-word-fall-through stream FIFO, DEPTH must be at least 1, no flush or clear input

`timescale 1ns/1ps
`default_nettype none

module redmule_stream_fifo #(
  parameter int unsigned DEPTH = 4,
  parameter type         T     = logic
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic push_valid_i,
  input  T     push_data_i,
  output logic push_ready_o,
  output logic pop_valid_o,
  output T     pop_data_o,
  input  logic pop_ready_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  T                 mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  // Wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push_ready_o = (count_q != CNT_W'(DEPTH));
  assign pop_valid_o  = (count_q != '0);
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign do_push = push_valid_i && push_ready_o;
  assign do_pop  = pop_valid_o && pop_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage only
  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= push_data_i;
  end

  a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    count_q <= CNT_W'(DEPTH))
    else $error("fifo occupancy above depth");

  // Empty means the read pointer has caught up with the write pointer
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (count_q == '0) |-> (rd_ptr_q == wr_ptr_q))
    else $error("fifo read pointer out of step with an empty fifo");

endmodule : redmule_stream_fifo

`default_nettype wire

// File: engine/redmule_engine.sv
// 4x4 integer accumulator array, products and sums truncated to 16 bits, no accumulator reset

`timescale 1ns/1ps
`default_nettype none

module redmule_engine
  import redmule_pkg::*;
  import redmule_ctrl_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  eng_cmd_t cmd_i,
  input  x_col_t   x_col_i,
  input  row_t     w_row_i,
  input  row_t     y_row_i,
  output row_t     z_row_o
);

  // acc_q[i][j] holds Z element (i, j)
  row_t [ARRAY_W-1:0] acc_q;

  always_ff @(posedge clk_i) begin
    case (cmd_i.op)
      LOAD_BIAS: begin
        acc_q[cmd_i.row] <= y_row_i;
      end
      MAC: begin
        // Outer product of one X column and one W row
        for (int i = 0; i < ARRAY_W; i++) begin
          for (int j = 0; j < ARRAY_H; j++) begin
            acc_q[i][j] <= acc_q[i][j] + elem_t'(x_col_i[i] * w_row_i[j]);
          end
        end
      end
      default: begin
        acc_q <= acc_q;
      end
    endcase
  end

  // Readout of the selected row
  assign z_row_o = acc_q[cmd_i.row];

  // Scheduler must only send legal ops
  a_legal_op: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cmd_i.op inside {NOP, LOAD_BIAS, MAC})
    else $error("undefined engine op %0d", cmd_i.op);

endmodule : redmule_engine

`default_nettype wire

// File: source/redmule_scheduler.sv
// Job FSM for one full 4x4 tile, start is ignored unless idle, K = 0 skips straight to store

`timescale 1ns/1ps
`default_nettype none

module redmule_scheduler
  import redmule_pkg::*;
  import redmule_ctrl_pkg::*;
(
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           start_i,
  input  logic [K_W-1:0] k_len_i,
  input  logic           x_valid_i,
  input  logic           w_valid_i,
  input  logic           y_valid_i,
  input  logic           z_ready_i,
  output logic           x_ready_o,
  output logic           w_ready_o,
  output logic           y_ready_o,
  output logic           z_valid_o,
  output eng_cmd_t       cmd_o,
  output logic           busy_o,
  output logic           done_o
);

  sched_state_e   state_q;
  sched_state_e   state_d;
  row_idx_t       row_q;
  row_idx_t       row_d;
  logic [K_W-1:0] step_q;
  logic [K_W-1:0] step_d;
  logic           last_row;
  logic           xw_valid;

  assign last_row = (row_q == row_idx_t'(ARRAY_W - 1));
  assign xw_valid = x_valid_i && w_valid_i;

  always_comb begin
    state_d   = state_q;
    row_d     = row_q;
    step_d    = step_q;
    x_ready_o = 1'b0;
    w_ready_o = 1'b0;
    y_ready_o = 1'b0;
    z_valid_o = 1'b0;
    done_o    = 1'b0;
    cmd_o     = '{op: NOP, row: row_q};

    case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = LOAD_Y;
          row_d   = '0;
          step_d  = k_len_i;
        end
      end
      LOAD_Y: begin
        y_ready_o = 1'b1;
        if (y_valid_i) begin
          cmd_o.op = LOAD_BIAS;
          row_d    = row_q + 1'b1;
          if (last_row) state_d = (step_q == '0) ? STORE : COMPUTE;
        end
      end
      COMPUTE: begin
        // X and W only leave their FIFOs as a pair
        x_ready_o = xw_valid;
        w_ready_o = xw_valid;
        if (xw_valid) begin
          cmd_o.op = MAC;
          step_d   = step_q - 1'b1;
          if (step_q == K_W'(1)) state_d = STORE;
        end
      end
      STORE: begin
        z_valid_o = 1'b1;
        if (z_ready_i) begin
          row_d = row_q + 1'b1;
          if (last_row) begin
            state_d = IDLE;
            done_o  = 1'b1;
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // Drops together with done
  assign busy_o = (state_q != IDLE) && !done_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      row_q   <= '0;
      step_q  <= '0;
    end else begin
      state_q <= state_d;
      row_q   <= row_d;
      step_q  <= step_d;
    end
  end

  a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_o |=> !done_o)
    else $error("done held for two cycles");

  a_xw_paired: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    x_ready_o == w_ready_o)
    else $error("x and w ready differ");

endmodule : redmule_scheduler

`default_nettype wire

// File: source/redmule_top.sv
// Integer tile engine Z = X*W + Y on valid/ready streams, K from 0 to 255, one job at a time

`timescale 1ns/1ps
`default_nettype none

module redmule_top
  import redmule_pkg::*;
  import redmule_ctrl_pkg::*;
#(
  parameter int unsigned X_DEPTH = 4,
  parameter int unsigned W_DEPTH = 4,
  parameter int unsigned Y_DEPTH = 4,
  parameter int unsigned Z_DEPTH = 2
) (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           start_i,
  input  logic [K_W-1:0] k_len_i,
  input  logic           x_valid_i,
  input  x_col_t         x_data_i,
  output logic           x_ready_o,
  input  logic           w_valid_i,
  input  row_t           w_data_i,
  output logic           w_ready_o,
  input  logic           y_valid_i,
  input  row_t           y_data_i,
  output logic           y_ready_o,
  output logic           z_valid_o,
  output row_t           z_data_o,
  input  logic           z_ready_i,
  output logic           busy_o,
  output logic           done_o
);

  // FIFO heads toward the engine and scheduler
  x_col_t   x_head;
  row_t     w_head;
  row_t     y_head;
  logic     x_head_valid, w_head_valid, y_head_valid;
  logic     x_pop, w_pop, y_pop;

  // Engine readout into the Z FIFO
  row_t     z_row;
  logic     z_push_valid, z_push_ready;
  eng_cmd_t eng_cmd;

  redmule_stream_fifo #(.DEPTH(X_DEPTH), .T(x_col_t)) i_x_fifo (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .push_valid_i(x_valid_i), .push_data_i(x_data_i), .push_ready_o(x_ready_o),
    .pop_valid_o(x_head_valid), .pop_data_o(x_head), .pop_ready_i(x_pop)
  );

  redmule_stream_fifo #(.DEPTH(W_DEPTH), .T(row_t)) i_w_fifo (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .push_valid_i(w_valid_i), .push_data_i(w_data_i), .push_ready_o(w_ready_o),
    .pop_valid_o(w_head_valid), .pop_data_o(w_head), .pop_ready_i(w_pop)
  );

  redmule_stream_fifo #(.DEPTH(Y_DEPTH), .T(row_t)) i_y_fifo (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .push_valid_i(y_valid_i), .push_data_i(y_data_i), .push_ready_o(y_ready_o),
    .pop_valid_o(y_head_valid), .pop_data_o(y_head), .pop_ready_i(y_pop)
  );

  redmule_stream_fifo #(.DEPTH(Z_DEPTH), .T(row_t)) i_z_fifo (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .push_valid_i(z_push_valid), .push_data_i(z_row), .push_ready_o(z_push_ready),
    .pop_valid_o(z_valid_o), .pop_data_o(z_data_o), .pop_ready_i(z_ready_i)
  );

  redmule_engine i_engine (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .cmd_i(eng_cmd),
    .x_col_i(x_head), .w_row_i(w_head), .y_row_i(y_head), .z_row_o(z_row)
  );

  redmule_scheduler i_scheduler (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .start_i(start_i), .k_len_i(k_len_i),
    .x_valid_i(x_head_valid), .w_valid_i(w_head_valid), .y_valid_i(y_head_valid),
    .z_ready_i(z_push_ready),
    .x_ready_o(x_pop), .w_ready_o(w_pop), .y_ready_o(y_pop), .z_valid_o(z_push_valid),
    .cmd_o(eng_cmd), .busy_o(busy_o), .done_o(done_o)
  );

endmodule : redmule_top

`default_nettype wire

// File: dv/redmule_tb.sv
// Random 4x4 tile jobs with K up to 15, inputs streamed with gaps, Z checked against a model

`timescale 1ns/1ps
`default_nettype none

module redmule_tb
  import redmule_pkg::*;
;

  localparam int          NUM_JOBS = 20;
  localparam int          LIMIT    = NUM_JOBS * (8 + 15) * 4 + 200;
  localparam logic [31:0] SEED     = 32'd82016;

  logic           clk_i;
  logic           rst_n_i;
  logic           start_i;
  logic [K_W-1:0] k_len_i;
  logic           z_valid_o;
  row_t           z_data_o;
  logic           z_ready_i;
  logic           busy_o;
  logic           done_o;

  // Stream sources, index 0 is Y, 1 is X, 2 is W
  logic           src_valid [3];
  logic [63:0]    src_data  [3];
  logic           src_ready [3];
  logic [63:0]    beat_mem  [3][512];
  int             beat_cnt  [3];

  // Expected Z rows in delivery order and job lengths
  row_t           z_exp [ARRAY_W * NUM_JOBS];
  logic [K_W-1:0] k_list [NUM_JOBS];

  logic           go;
  logic           in_job;
  int             errors;
  int             rows_rx;
  int             dones;
  int             starts_idle;

  always #20 clk_i = ~clk_i;

  redmule_top dut (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .start_i(start_i), .k_len_i(k_len_i),
    .x_valid_i(src_valid[1]), .x_data_i(src_data[1]), .x_ready_o(src_ready[1]),
    .w_valid_i(src_valid[2]), .w_data_i(src_data[2]), .w_ready_o(src_ready[2]),
    .y_valid_i(src_valid[0]), .y_data_i(src_data[0]), .y_ready_o(src_ready[0]),
    .z_valid_o(z_valid_o), .z_data_o(z_data_o), .z_ready_i(z_ready_i),
    .busy_o(busy_o), .done_o(done_o)
  );

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic draw(inout logic [31:0] st, input int n, output logic [31:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      v = {v[30:0], st[0]};
      st = lfsr_step(st);
    end
  endtask

  task automatic build_jobs(inout logic [31:0] st);
    logic [31:0] lo;
    logic [31:0] hi;
    logic [31:0] r;
    row_t        acc [ARRAY_W];
    x_col_t      xc;
    row_t        wr;
    for (int j = 0; j < NUM_JOBS; j++) begin
      draw(st, 4, r);
      // Some jobs forced to K = 0
      k_list[j] = (j % 7 == 3) ? '0 : K_W'(r[3:0]);
      for (int i = 0; i < ARRAY_W; i++) begin
        draw(st, 32, lo);
        draw(st, 32, hi);
        acc[i] = {hi, lo};
        beat_mem[0][beat_cnt[0]] = {hi, lo};
        beat_cnt[0] = beat_cnt[0] + 1;
      end
      for (int k = 0; k < int'(k_list[j]); k++) begin
        draw(st, 32, lo);
        draw(st, 32, hi);
        xc = {hi, lo};
        draw(st, 32, lo);
        draw(st, 32, hi);
        wr = {hi, lo};
        beat_mem[1][beat_cnt[1]] = xc;
        beat_mem[2][beat_cnt[2]] = wr;
        beat_cnt[1] = beat_cnt[1] + 1;
        beat_cnt[2] = beat_cnt[2] + 1;
        // Element (i, c) gains X(i, k) * W(k, c), wrapping at 16 bits
        for (int i = 0; i < ARRAY_W; i++) begin
          for (int c = 0; c < ARRAY_H; c++) begin
            acc[i][c] = acc[i][c] + xc[i] * wr[c];
          end
        end
      end
      for (int i = 0; i < ARRAY_W; i++) begin
        z_exp[j * ARRAY_W + i] = acc[i];
      end
    end
  endtask

  // Pushes one stream, valid and data held until the beat is taken
  task automatic drive_source(input int s);
    logic [31:0] st;
    logic [31:0] r;
    logic        held;
    int          idx;
    st   = SEED + 32'(s) + 32'd1;
    idx  = 0;
    held = 1'b0;
    wait (go);
    forever begin
      @(posedge clk_i);
      #2;
      draw(st, 2, r);
      if (!held) begin
        src_valid[s] = (idx < beat_cnt[s]) && (r[1:0] != 2'd0);
        src_data[s]  = beat_mem[s][idx];
      end
      @(negedge clk_i);
      held = src_valid[s] && !src_ready[s];
      if (src_valid[s] && src_ready[s]) idx++;
    end
  endtask

  task automatic finish_run();
    $display("Summary: %0d errors, %0d rows checked, %0d jobs done", errors, rows_rx, dones);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  initial drive_source(0);
  initial drive_source(1);
  initial drive_source(2);

  // Z sink with random back-pressure
  initial begin : z_receiver
    logic [31:0] st;
    logic [31:0] r;
    st = SEED ^ 32'h0000_00f0;
    wait (go);
    forever begin
      @(negedge clk_i);
      if (z_valid_o && z_ready_i) begin
        if (rows_rx >= ARRAY_W * NUM_JOBS) begin
          $display("Z row received after all jobs were delivered");
          errors++;
        end else if (z_data_o !== z_exp[rows_rx]) begin
          $display("ERR z_data_o job %0d row %0d: expected %h, got %h",
                   rows_rx / ARRAY_W, rows_rx % ARRAY_W, z_exp[rows_rx], z_data_o);
          errors++;
        end
        rows_rx++;
      end
      @(posedge clk_i);
      #2;
      draw(st, 1, r);
      z_ready_i = r[0];
    end
  end

  // Busy follows accepted starts and drops with done
  initial begin : job_monitor
    wait (go);
    forever begin
      @(negedge clk_i);
      if (busy_o !== (in_job && !done_o)) begin
        $display("ERR busy_o: expected %h, got %h", in_job && !done_o, busy_o);
        errors++;
      end
      if (start_i && !busy_o) starts_idle++;
      if (done_o) begin
        if (!in_job) begin
          $display("done_o pulsed while no job was running");
          errors++;
        end
        dones++;
        in_job = 1'b0;
      end else if (start_i && !in_job) begin
        in_job = 1'b1;
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < LIMIT) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout after %0d cycles with %0d of %0d jobs done", cycles, dones, NUM_JOBS);
    errors++;
    finish_run();
  end

  initial begin : main_seq
    logic [31:0] st;
    logic [31:0] r;
    int          j;
    clk_i     = 1'b0;
    rst_n_i   = 1'b0;
    start_i   = 1'b0;
    k_len_i   = '0;
    z_ready_i = 1'b0;
    go        = 1'b0;
    in_job    = 1'b0;
    errors    = 0;
    rows_rx   = 0;
    dones     = 0;
    starts_idle = 0;
    for (int s = 0; s < 3; s++) begin
      src_valid[s] = 1'b0;
      src_data[s]  = '0;
      beat_cnt[s]  = 0;
    end
    st = SEED;
    build_jobs(st);
    repeat (10) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    @(negedge clk_i);
    // Order is busy, done, z_valid, x_ready, w_ready, y_ready
    if ({busy_o, done_o, z_valid_o, src_ready[1], src_ready[2], src_ready[0]} !== 6'b000111) begin
      $display("ERR {busy_o,done_o,z_valid_o,x_ready_o,w_ready_o,y_ready_o}: expected %h, got %h",
               6'b000111, {busy_o, done_o, z_valid_o, src_ready[1], src_ready[2], src_ready[0]});
      errors++;
    end
    go = 1'b1;
    j  = 0;
    while (j < NUM_JOBS) begin
      @(posedge clk_i);
      #2;
      start_i = 1'b0;
      draw(st, 3, r);
      if (!in_job) begin
        start_i = 1'b1;
        k_len_i = k_list[j];
        j++;
      end else if (busy_o && r[2:0] == 3'd0) begin
        // Extra start while busy, must be ignored
        draw(st, 8, r);
        start_i = 1'b1;
        k_len_i = r[7:0];
      end
    end
    @(posedge clk_i);
    #2;
    start_i = 1'b0;
    while (dones < NUM_JOBS || rows_rx < ARRAY_W * NUM_JOBS) @(posedge clk_i);
    repeat (20) @(posedge clk_i);
    if (dones != starts_idle || dones != NUM_JOBS) begin
      $display("ERR done_o count: expected %h, got %h", starts_idle, dones);
      errors++;
    end
    if (rows_rx != ARRAY_W * NUM_JOBS) begin
      $display("ERR z_valid_o row count: expected %h, got %h", ARRAY_W * NUM_JOBS, rows_rx);
      errors++;
    end
    finish_run();
  end

endmodule : redmule_tb

`default_nettype wire

// File: sources.f
common/redmule_pkg.sv
common/redmule_ctrl_pkg.sv
source/redmule_stream_fifo.sv
engine/redmule_engine.sv
source/redmule_scheduler.sv
source/redmule_top.sv
dv/redmule_tb.sv

// File: run.sh
#!/bin/sh
# Verilator build and run, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal -f sources.f --top-module redmule_tb \
  -Mdir obj_dir -o redmule_sim \
  && ./obj_dir/redmule_sim > sim.log 2>&1 \
  && cat sim.log \
  && ! grep -q "STATUS: FAIL" sim.log \
  || { cat sim.log 2>/dev/null; echo "simulation failed"; exit 1; }
